//--- all.f
+incdir+verification
common/scope_cmd_pkg.sv
common/scope_acq_pkg.sv
host_link/cmd_receiver.sv
host_link/cmd_executor.sv
acquisition/trigger_fsm.sv
acquisition/sample_buffer.sv
verilog/scope_top.sv
verification/tb_scope_top.sv

//--- verification/tb_scope_tasks.svh
//--------------------------------------------------------------------------
// scope testbench tasks
// host byte stream, reply receive, checks and the directed tests
//--------------------------------------------------------------------------

`ifndef TB_SCOPE_TASKS_SVH
`define TB_SCOPE_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
	if (got !== exp) begin
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
		value_errs++;
	end
endtask

task automatic note_failure(input string msg);
	$display("Error: %s", msg);
	other_errs++;
endtask

// called on a falling edge, returns on the falling edge after the transfer
task automatic send_byte(input logic [7:0] data);
	i_rx_tvalid = 1'b1;
	i_rx_tdata  = data;
	while (!o_rx_tready) @(negedge clk);
	@(negedge clk);
	i_rx_tvalid = 1'b0;
endtask

// op first, then args from byte1 in the top byte down to byte7
task automatic send_cmd(input logic [7:0] op, input logic [55:0] args);
	int i;
	send_byte(op);
	for (i = 6; i >= 0; i--) send_byte(args[i*8 +: 8]);
	// command strobe cycle, the link is busy now
	check_value("o_rx_tready after command", o_rx_tready, 1'b0);
endtask

task automatic recv_beat(input int max_wait, output logic got, output logic [31:0] data,
                         output logic [3:0] keep, output logic last);
	logic [31:0] rnd;
	int          n;
	got  = 1'b0;
	data = '0;
	keep = '0;
	last = 1'b0;
	for (n = 0; n < max_wait && !got; n++) begin
		rnd         = $random(seed);
		i_tx_tready = random_ready ? rnd[0] : 1'b1;
		if (o_tx_tvalid && i_tx_tready) begin  // beat moves on the next rising edge
			got  = 1'b1;
			data = o_tx_tdata;
			keep = o_tx_tkeep;
			last = o_tx_tlast;
		end
		@(negedge clk);
	end
	i_tx_tready = 1'b0;
endtask

task automatic expect_reply(input string what, input logic [31:0] exp_data);
	logic        got;
	logic [31:0] data;
	logic [3:0]  keep;
	logic        last;
	recv_beat(100, got, data, keep, last);
	if (!got) begin
		note_failure({"no reply to ", what});
	end else begin
		check_value({what, " o_tx_tdata"}, data, exp_data);
		check_value({what, " o_tx_tkeep"}, keep, 4'b1111);
		check_value({what, " o_tx_tlast"}, last, 1'b1);
	end
endtask

// ARM_STATUS until the status word matches, length goes in {byte5, byte4}
task automatic poll_event(input logic [7:0] trig, input logic [15:0] len,
                          input logic [31:0] target);
	logic        got;
	logic [31:0] data;
	logic [3:0]  keep;
	logic        last;
	int          n;
	data = '0;
	for (n = 0; n < 40 && data !== target; n++) begin
		send_cmd(8'd1, {trig, 16'd0, len[7:0], len[15:8], 16'd0});
		recv_beat(100, got, data, keep, last);
	end
	if (data !== target)
		note_failure($sformatf("event not captured, last status 0x%h", data));
endtask

task automatic read_block(input logic [31:0] nbytes);
	int          beats;
	int          exp_beats;
	int          tail;
	logic        got;
	logic        last;
	logic        done;
	logic [31:0] data;
	logic [3:0]  keep;
	rd_samples = {};
	exp_beats  = (nbytes + 3) / 4;
	tail       = nbytes - 4 * (exp_beats - 1);  // bytes in the final beat
	beats      = 0;
	done       = 1'b0;
	// length goes in {byte7 .. byte4}, byte7 on top
	send_cmd(8'd0, {24'd0, nbytes[7:0], nbytes[15:8], nbytes[23:16], nbytes[31:24]});
	while (!done) begin
		recv_beat(200, got, data, keep, last);
		if (!got) begin
			note_failure("readout stopped before the last beat");
			done = 1'b1;
		end else begin
			beats++;
			check_value("o_tx_tkeep", keep, (beats < exp_beats) ? 4'hF : 4'hF >> (4 - tail));
			check_value("o_tx_tlast", last, beats == exp_beats);
			check_value("o_tx_tdata unused bits", data & 32'hF000_F000, 32'd0);
			rd_samples.push_back(data[11:0]);
			rd_samples.push_back(data[27:16]);
			done = last || (beats >= exp_beats);
		end
	end
	check_value("readout beat count", beats, exp_beats);
endtask

// downsample 2 on a one-per-clk ramp leaves a step of 4
task automatic check_ramp_steps();
	logic [11:0] step;
	int          i;
	for (i = 1; i < rd_samples.size(); i++) begin
		step = rd_samples[i] - rd_samples[i-1];
		check_value("ramp sample step", step, 12'd4);
	end
endtask

//--------------------------------------------------------------------------
// directed tests
//--------------------------------------------------------------------------
task automatic read_version();
	send_cmd(8'd2, 56'd0);
	expect_reply("READ_INFO", EXP_VERSION);
endtask

task automatic settings_and_unknown();
	logic        got;
	logic [31:0] data;
	logic [3:0]  keep;
	logic        last;
	send_cmd(8'd8, {8'd128, 8'd32, 40'd0});
	expect_reply("TRIG_SET", 32'd8);
	send_cmd(8'd9, {8'd0, 48'd0});
	expect_reply("DS_SET", 32'd9);
	send_cmd(8'h55, 56'd0);
	recv_beat(50, got, data, keep, last);
	if (got) note_failure("unknown opcode 0x55 produced a reply");
	read_version();
endtask

task automatic capture_ramp(input logic back_pressure);
	random_ready = back_pressure;
	use_ramp     = 1'b1;
	send_cmd(8'd9, {8'd2, 48'd0});                 // write every 4th cycle
	expect_reply("DS_SET", 32'd9);
	send_cmd(8'd8, {8'd128, 8'd32, 40'd0});        // pre-offset 0
	expect_reply("TRIG_SET", 32'd8);
	exp_events++;
	poll_event(8'd0, 16'd20, {exp_events, 16'hFFFF});
	read_block(32'd40);
	check_ramp_steps();
	random_ready = 1'b0;
endtask

task automatic partial_beat();
	read_block(32'd14);
	check_ramp_steps();
endtask

// thresholds -504 and +520, pre-offset 8, tot_count 3
task automatic rising_trigger();
	int i;
	use_ramp = 1'b0;
	level    = 12'sd1000;
	send_cmd(8'd9, 56'd0);
	expect_reply("DS_SET", 32'd9);
	send_cmd(8'd8, {8'd128, 8'd32, 8'd0, 8'd8, 8'd3, 16'd0});
	expect_reply("TRIG_SET", 32'd8);
	send_cmd(8'd1, {8'd2, 16'd0, 8'd16, 8'd0, 16'd0});
	expect_reply("ARM_STATUS rising", {exp_events, 16'd0});
	repeat (12) @(negedge clk);
	level = -12'sd1000;
	exp_events++;
	poll_event(8'd2, 16'd16, {exp_events, 16'hFFFF});
	read_block(32'd32);
	// trigger address holds the 4th low hit, so 8 - 3 high samples come first
	for (i = 0; i < rd_samples.size(); i++)
		check_value("rising readout sample", rd_samples[i], (i < 5) ? 12'd1000 : 12'hC18);
	// this status read also arms a one-sample immediate capture
	send_cmd(8'd1, {8'd0, 16'd0, 8'd1, 8'd0, 16'd0});
	expect_reply("ARM_STATUS after readout", {exp_events, 16'd0});
	exp_events++;
	poll_event(8'd0, 16'd1, {exp_events, 16'hFFFF});
	send_cmd(8'd0, 56'd0);                         // empty readout releases the event
	repeat (4) @(negedge clk);
endtask

`endif

//--- verification/tb_scope_top.sv
//--------------------------------------------------------------------------
// tb_scope_top
// testbench for the scope controller core, drives host commands and
// samples and checks replies and buffer readouts
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_scope_top;
	import scope_acq_pkg::*;

	localparam int          CLK_HALF    = 10;   // 20 ns period
	localparam int unsigned EXP_VERSION = 17;

	// cycle budget of each test, summed for the watchdog
	localparam int VERSION_CYC  = 200;
	localparam int SETTINGS_CYC = 500;
	localparam int CAPTURE_CYC  = 2000;
	localparam int PARTIAL_CYC  = 300;
	localparam int RISE_CYC     = 2500;
	localparam int BP_CYC       = 4000;  // random ready roughly doubles the time
	localparam int MARGIN_CYC   = 1000;
	localparam int WATCHDOG_CYC = VERSION_CYC + SETTINGS_CYC + CAPTURE_CYC + PARTIAL_CYC +
	                              RISE_CYC + BP_CYC + MARGIN_CYC;

	logic        clk;
	logic        rstn;
	logic        i_rx_tvalid;
	logic [7:0]  i_rx_tdata;
	logic        o_rx_tready;
	logic        o_tx_tvalid;
	logic [31:0] o_tx_tdata;
	logic [3:0]  o_tx_tkeep;
	logic        o_tx_tlast;
	logic        i_tx_tready;
	sample_t     i_sample;

	integer      seed;
	int          value_errs;
	int          other_errs;
	logic [31:0] cycle_cnt;
	logic        use_ramp;       // ramp or fixed level on i_sample
	sample_t     level;
	logic        random_ready;   // back-pressure on the reply stream
	logic [15:0] exp_events;
	logic [11:0] rd_samples [$]; // samples of the last readout, in order

	scope_top #(
		.BUF_AW           (10),
		.FIRMWARE_VERSION (EXP_VERSION)
	) i_scope_top (
		.clk         (clk),
		.rstn        (rstn),
		.i_rx_tvalid (i_rx_tvalid),
		.i_rx_tdata  (i_rx_tdata),
		.o_rx_tready (o_rx_tready),
		.o_tx_tvalid (o_tx_tvalid),
		.o_tx_tdata  (o_tx_tdata),
		.o_tx_tkeep  (o_tx_tkeep),
		.o_tx_tlast  (o_tx_tlast),
		.i_tx_tready (i_tx_tready),
		.i_sample    (i_sample)
	);

	always #(CLK_HALF) clk = ~clk;

	// one sample per clk, changed on the falling edge
	always @(negedge clk) begin
		cycle_cnt <= cycle_cnt + 32'd1;
		i_sample  <= use_ramp ? sample_t'(cycle_cnt[11:0]) : level;
	end

	`include "tb_scope_tasks.svh"

	//--------------------------------------------------------------------------
	// test sequence
	//--------------------------------------------------------------------------
	initial begin
		clk          = 1'b0;
		rstn         = 1'b0;
		i_rx_tvalid  = 1'b0;
		i_rx_tdata   = 8'd0;
		i_tx_tready  = 1'b0;
		i_sample     = '0;
		seed         = 70220;
		value_errs   = 0;
		other_errs   = 0;
		cycle_cnt    = 32'd0;
		use_ramp     = 1'b1;
		level        = '0;
		random_ready = 1'b0;
		exp_events   = 16'd0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		// both streams stay quiet in reset
		check_value("o_rx_tready in reset", o_rx_tready, 1'b0);
		check_value("o_tx_tvalid in reset", o_tx_tvalid, 1'b0);
		rstn = 1'b1;
		@(negedge clk);

		read_version();
		settings_and_unknown();
		capture_ramp(1'b0);
		partial_beat();
		rising_trigger();
		capture_ramp(1'b1);  // same capture under back-pressure

		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// ends a hung run
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles, test sequence did not finish",
		         WATCHDOG_CYC);
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/scope_top.sv
//--------------------------------------------------------------------------
// scope_top
// oscilloscope controller core, host command link plus acquisition path
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module scope_top #(
	parameter int          BUF_AW           = 10,
	parameter int unsigned FIRMWARE_VERSION = 17
) (
	input  logic                   clk,
	input  logic                   rstn,
	// host command bytes
	input  logic                   i_rx_tvalid,
	input  logic [7:0]             i_rx_tdata,
	output logic                   o_rx_tready,
	// reply stream
	output logic                   o_tx_tvalid,
	output logic [31:0]            o_tx_tdata,
	output logic [3:0]             o_tx_tkeep,
	output logic                   o_tx_tlast,
	input  logic                   i_tx_tready,
	// ADC samples, one per clk
	input  scope_acq_pkg::sample_t i_sample
);
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;

	cmd_t              cmd;
	logic              cmd_valid;
	logic              busy;
	acq_cfg_t          cfg;
	logic              arm;
	logic              readout_done;
	acq_status_t       status;
	logic [BUF_AW-1:0] rd_addr;
	sample_t [1:0]     rd_data;
	logic              wr_en;
	logic [BUF_AW-1:0] wr_addr;
	sample_t           wr_data;

	cmd_receiver u_cmd_receiver (
		.clk         (clk),
		.rstn        (rstn),
		.i_rx_tvalid (i_rx_tvalid),
		.i_rx_tdata  (i_rx_tdata),
		.i_busy      (busy),
		.o_rx_tready (o_rx_tready),
		.o_cmd       (cmd),
		.o_cmd_valid (cmd_valid)
	);

	cmd_executor #(
		.BUF_AW           (BUF_AW),
		.FIRMWARE_VERSION (FIRMWARE_VERSION)
	) u_cmd_executor (
		.clk            (clk),
		.rstn           (rstn),
		.i_cmd          (cmd),
		.i_cmd_valid    (cmd_valid),
		.i_status       (status),
		.i_rd_data      (rd_data),
		.i_tx_tready    (i_tx_tready),
		.o_busy         (busy),
		.o_cfg          (cfg),
		.o_arm          (arm),
		.o_readout_done (readout_done),
		.o_rd_addr      (rd_addr),
		.o_tx_tvalid    (o_tx_tvalid),
		.o_tx_tdata     (o_tx_tdata),
		.o_tx_tkeep     (o_tx_tkeep),
		.o_tx_tlast     (o_tx_tlast)
	);

	trigger_fsm #(
		.BUF_AW (BUF_AW)
	) u_trigger_fsm (
		.clk            (clk),
		.rstn           (rstn),
		.i_sample       (i_sample),
		.i_cfg          (cfg),
		.i_arm          (arm),
		.i_readout_done (readout_done),
		.o_status       (status),
		.o_wr_en        (wr_en),
		.o_wr_addr      (wr_addr),
		.o_wr_data      (wr_data)
	);

	sample_buffer #(
		.BUF_AW (BUF_AW)
	) u_sample_buffer (
		.clk       (clk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

endmodule

//--- acquisition/sample_buffer.sv
//--------------------------------------------------------------------------
// sample_buffer
// circular sample memory, one write port and a registered read of two
// neighbouring entries
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module sample_buffer #(
	parameter int BUF_AW = 10
) (
	input  logic                         clk,
	input  logic                         i_wr_en,
	input  logic [BUF_AW-1:0]            i_wr_addr,
	input  scope_acq_pkg::sample_t       i_wr_data,
	input  logic [BUF_AW-1:0]            i_rd_addr,
	output scope_acq_pkg::sample_t [1:0] o_rd_data
);
	import scope_acq_pkg::*;

	localparam int DEPTH = 2 ** BUF_AW;

	sample_t           mem [DEPTH];
	logic [BUF_AW-1:0] rd_addr_nxt;   // wraps at the buffer end

	assign rd_addr_nxt = i_rd_addr + 1'b1;

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	always_ff @(posedge clk) begin
		o_rd_data[0] <= mem[i_rd_addr];
		o_rd_data[1] <= mem[rd_addr_nxt];
	end

endmodule

//--- acquisition/trigger_fsm.sv
//--------------------------------------------------------------------------
// trigger_fsm
// sets the buffer write cadence, detects threshold triggers, counts the
// post-trigger samples and holds the event for readout
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module trigger_fsm #(
	parameter int BUF_AW = 10
) (
	input  logic                       clk,
	input  logic                       rstn,
	input  scope_acq_pkg::sample_t     i_sample,
	input  scope_acq_pkg::acq_cfg_t    i_cfg,
	input  logic                       i_arm,
	input  logic                       i_readout_done,
	output scope_acq_pkg::acq_status_t o_status,
	output logic                       o_wr_en,
	output logic [BUF_AW-1:0]          o_wr_addr,
	output scope_acq_pkg::sample_t     o_wr_data
);
	import scope_acq_pkg::*;

	acq_state_e        state;
	sample_t           sample_q;
	logic [31:0]       ds_cnt;       // counts 1 up to 2^downsample
	logic              ds_tick;
	logic [7:0]        tot_cnt;
	logic [15:0]       trig_cnt;
	logic [15:0]       cap_next;
	logic              cap_done;
	logic [15:0]       evt_cnt;
	logic [BUF_AW-1:0] trig_addr_q;

	if (BUF_AW > BUF_AW_MAX) begin : g_aw_check
		$error("BUF_AW is wider than the status trigger address");
	end

	assign ds_tick   = ds_cnt[i_cfg.downsample];
	assign cap_next  = trig_cnt + 16'd1;
	assign cap_done  = (trig_cnt >= i_cfg.length_to_take) ||
	                   (o_wr_en && (cap_next >= i_cfg.length_to_take));
	assign o_wr_data = sample_q;
	assign o_status  = '{trigger_count: trig_cnt,
	                     event_count:   evt_cnt,
	                     trig_addr:     BUF_AW_MAX'(trig_addr_q)};

	always_ff @(posedge clk) begin
		sample_q <= i_sample;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= ACQ_READY;
			ds_cnt      <= 32'd1;
			o_wr_en     <= 1'b0;
			o_wr_addr   <= '0;
			trig_addr_q <= '0;
			tot_cnt     <= '0;
			trig_cnt    <= '0;
			evt_cnt     <= '0;
		end else begin
			// write cadence, frozen while an event is held
			if (state == ACQ_HOLD) begin
				ds_cnt  <= 32'd1;
				o_wr_en <= 1'b0;
			end else begin
				ds_cnt  <= ds_tick ? 32'd1 : ds_cnt + 32'd1;
				o_wr_en <= ds_tick;
			end
			if (o_wr_en) o_wr_addr <= o_wr_addr + 1'b1;

			case (state)
				ACQ_READY: begin
					trig_cnt <= '0;
					tot_cnt  <= '0;
					if (i_arm) begin
						case (i_cfg.trig_type)
							TRIG_FALL: state <= ACQ_FALL_ARM;
							TRIG_RISE: state <= ACQ_RISE_ARM;
							default: begin             // TRIG_NONE captures at once
								trig_addr_q <= o_wr_addr;
								state       <= ACQ_CAPTURE;
							end
						endcase
					end
				end
				ACQ_FALL_ARM: begin
					if (sample_q < i_cfg.lower_thresh) state <= ACQ_FALL_HIT;
				end
				ACQ_FALL_HIT: begin
					if (sample_q > i_cfg.upper_thresh) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_cfg.tot_count) begin
							trig_addr_q <= o_wr_addr;
							state       <= ACQ_CAPTURE;
						end
					end
				end
				ACQ_RISE_ARM: begin
					if (sample_q > i_cfg.upper_thresh) state <= ACQ_RISE_HIT;
				end
				ACQ_RISE_HIT: begin
					if (sample_q < i_cfg.lower_thresh) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_cfg.tot_count) begin
							trig_addr_q <= o_wr_addr;
							state       <= ACQ_CAPTURE;
						end
					end
				end
				ACQ_CAPTURE: begin
					if (o_wr_en) trig_cnt <= cap_next;
					if (cap_done) begin
						state    <= ACQ_HOLD;
						evt_cnt  <= evt_cnt + 16'd1;
						trig_cnt <= '1;       // tells the host an event is ready
						ds_cnt   <= 32'd1;
						o_wr_en  <= 1'b0;     // no write past the last capture
					end
				end
				ACQ_HOLD: begin
					if (i_readout_done) begin
						trig_cnt <= '0;
						state    <= ACQ_READY;
					end
				end
				default: state <= ACQ_READY;
			endcase
		end
	end

	// the address only moves past a slot that was just written, and never
	// while an event is held
	a_addr_on_write: assert property (@(posedge clk) disable iff (!rstn)
		!$stable(o_wr_addr) |-> ($past(o_wr_en) && ($past(state) != ACQ_HOLD)));

endmodule

//--- host_link/cmd_executor.sv
//--------------------------------------------------------------------------
// cmd_executor
// decodes host commands, keeps acquisition settings, sends constant replies
// and streams buffer samples back to the host
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module cmd_executor #(
	parameter int          BUF_AW           = 10,
	parameter int unsigned FIRMWARE_VERSION = 17
) (
	input  logic                         clk,
	input  logic                         rstn,
	input  scope_cmd_pkg::cmd_t          i_cmd,
	input  logic                         i_cmd_valid,
	input  scope_acq_pkg::acq_status_t   i_status,
	input  scope_acq_pkg::sample_t [1:0] i_rd_data,
	input  logic                         i_tx_tready,
	output logic                         o_busy,
	output scope_acq_pkg::acq_cfg_t      o_cfg,
	output logic                         o_arm,
	output logic                         o_readout_done,
	output logic [BUF_AW-1:0]            o_rd_addr,
	output logic                         o_tx_tvalid,
	output logic [31:0]                  o_tx_tdata,
	output logic [3:0]                   o_tx_tkeep,
	output logic                         o_tx_tlast
);
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;

	typedef enum logic [2:0] {
		EX_IDLE,
		EX_DECODE,
		EX_REPLY,    // one constant beat
		EX_RD_WAIT,  // buffer read latency
		EX_RD_LOAD,
		EX_RD_SEND
	} ex_state_e;

	ex_state_e   state;
	logic [9:0]  pre_offset;   // samples shown before the trigger
	logic [31:0] rd_len;       // bytes still to send
	logic [31:0] rd_bytes;
	logic        reply_en;
	logic [31:0] reply_data;
	logic [7:0]  thr_lo_base;
	logic [7:0]  thr_hi_base;
	logic [3:0]  tail_keep;

	assign o_busy = (state != EX_IDLE) | i_cmd_valid;

	assign rd_bytes    = {i_cmd.byte7, i_cmd.byte6, i_cmd.byte5, i_cmd.byte4};
	assign thr_lo_base = i_cmd.byte1 - i_cmd.byte2 - 8'd128;
	assign thr_hi_base = i_cmd.byte1 + i_cmd.byte2 - 8'd128;

	//--------------------------------------------------------------------------
	// constant replies
	//--------------------------------------------------------------------------
	always_comb begin
		reply_en   = 1'b0;
		reply_data = '0;
		case (i_cmd.op)
			TRIG_SET: begin
				reply_en   = 1'b1;
				reply_data = 32'(TRIG_SET);   // echo the opcode
			end
			DS_SET: begin
				reply_en   = 1'b1;
				reply_data = 32'(DS_SET);
			end
			ARM_STATUS: begin
				reply_en   = 1'b1;
				reply_data = {i_status.event_count, i_status.trigger_count};
			end
			READ_INFO: begin
				if (i_cmd.byte1 == INFO_VERSION) begin
					reply_en   = 1'b1;
					reply_data = 32'(FIRMWARE_VERSION);
				end
			end
			default: ;
		endcase
	end

	// keep for a final beat of 1 to 4 bytes
	always_comb begin
		case (rd_len[1:0])
			2'd1:    tail_keep = 4'b0001;
			2'd2:    tail_keep = 4'b0011;
			2'd3:    tail_keep = 4'b0111;
			default: tail_keep = 4'b1111;
		endcase
	end

	//--------------------------------------------------------------------------
	// control FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= EX_IDLE;
			o_cfg          <= '0;
			pre_offset     <= '0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			o_rd_addr      <= '0;
			rd_len         <= '0;
			o_tx_tvalid    <= 1'b0;
		end else begin
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			case (state)
				EX_IDLE: begin
					if (i_cmd_valid) state <= EX_DECODE;
				end
				EX_DECODE: begin
					state       <= reply_en ? EX_REPLY : EX_IDLE;  // unknown ops just drop
					o_tx_tvalid <= reply_en;
					case (i_cmd.op)
						TRIG_SET: begin
							o_cfg.lower_thresh <= sample_t'({thr_lo_base, 4'h8});  // x16 + 8
							o_cfg.upper_thresh <= sample_t'({thr_hi_base, 4'h8});
							o_cfg.tot_count    <= i_cmd.byte5;
							pre_offset         <= {i_cmd.byte3[1:0], i_cmd.byte4};
						end
						DS_SET: o_cfg.downsample <= i_cmd.byte1[4:0];
						ARM_STATUS: begin
							o_cfg.trig_type      <= trig_type_e'(i_cmd.byte1);
							o_cfg.length_to_take <= {i_cmd.byte5, i_cmd.byte4};
							o_arm                <= (i_status.trigger_count == 16'd0);  // no event pending
						end
						READOUT: begin
							o_rd_addr <= i_status.trig_addr[BUF_AW-1:0] - pre_offset[BUF_AW-1:0];
							rd_len    <= rd_bytes;
							if (rd_bytes == 32'd0) o_readout_done <= 1'b1;
							else                   state <= EX_RD_WAIT;
						end
						default: ;
					endcase
				end
				EX_REPLY: begin
					if (i_tx_tready) begin
						o_tx_tvalid <= 1'b0;
						state       <= EX_IDLE;
					end
				end
				EX_RD_WAIT: state <= EX_RD_LOAD;
				EX_RD_LOAD: begin
					o_tx_tvalid <= 1'b1;
					o_rd_addr   <= o_rd_addr + BUF_AW'(2);  // two samples per beat
					state       <= EX_RD_SEND;
				end
				EX_RD_SEND: begin
					if (i_tx_tready) begin
						o_tx_tvalid <= 1'b0;
						if (rd_len > 32'd4) begin
							rd_len <= rd_len - 32'd4;
							state  <= EX_RD_LOAD;   // rd_data already follows the new address
						end else begin
							rd_len         <= '0;
							o_readout_done <= 1'b1;
							state          <= EX_IDLE;
						end
					end
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

	// beat payload, loaded once per beat and held until accepted
	always_ff @(posedge clk) begin
		if (state == EX_DECODE) begin
			o_tx_tdata <= reply_data;
			o_tx_tkeep <= 4'b1111;
			o_tx_tlast <= 1'b1;
		end else if (state == EX_RD_LOAD) begin
			o_tx_tdata <= {4'd0, i_rd_data[1], 4'd0, i_rd_data[0]};
			o_tx_tkeep <= (rd_len > 32'd4) ? 4'b1111 : tail_keep;
			o_tx_tlast <= (rd_len <= 32'd4);
		end
	end

	// a stalled beat stays put until the host takes it
	a_tx_stable: assert property (@(posedge clk) disable iff (!rstn)
		(o_tx_tvalid && !i_tx_tready) |=>
			(o_tx_tvalid && $stable(o_tx_tdata) && $stable(o_tx_tkeep) && $stable(o_tx_tlast)));

endmodule

//--- host_link/cmd_receiver.sv
//--------------------------------------------------------------------------
// cmd_receiver
// shifts eight host stream bytes into one command and strobes it out
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module cmd_receiver (
	input  logic                clk,
	input  logic                rstn,
	input  logic                i_rx_tvalid,
	input  logic [7:0]          i_rx_tdata,
	input  logic                i_busy,
	output logic                o_rx_tready,
	output scope_cmd_pkg::cmd_t o_cmd,
	output logic                o_cmd_valid
);
	import scope_cmd_pkg::*;

	localparam int CNT_W = $clog2(CMD_BYTES);

	logic                   link_up;   // stays low through reset
	logic [CNT_W-1:0]       byte_cnt;
	logic                   rx_fire;
	logic                   last_byte;
	logic [CMD_BYTES*8-1:0] shreg;

	assign o_rx_tready = link_up & ~i_busy;
	assign rx_fire     = i_rx_tvalid & o_rx_tready;
	assign last_byte   = (byte_cnt == CNT_W'(CMD_BYTES - 1));
	assign o_cmd       = shreg;        // op ends up in the top byte

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			link_up     <= 1'b0;
			byte_cnt    <= '0;
			o_cmd_valid <= 1'b0;
		end else begin
			link_up     <= 1'b1;
			o_cmd_valid <= rx_fire & last_byte;
			if (rx_fire) begin
				byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_fire) begin
			shreg <= {shreg[CMD_BYTES*8-9:0], i_rx_tdata};
		end
	end

	// the executor must raise busy right after the last byte, and no byte
	// may slip in while the command is being handled
	a_no_byte_while_busy: assert property (@(posedge clk) disable iff (!rstn)
		(rx_fire && last_byte) |=> (i_busy && !rx_fire));

endmodule

//--- common/scope_acq_pkg.sv
//--------------------------------------------------------------------------
// scope acquisition package
// sample type, trigger FSM states, acquisition settings and status words
//--------------------------------------------------------------------------

package scope_acq_pkg;

	// widest buffer address the status word can carry
	localparam int BUF_AW_MAX = 10;

	typedef logic signed [11:0] sample_t;

	typedef enum logic [2:0] {
		ACQ_READY,     // writing history, waiting for arm
		ACQ_FALL_ARM,  // falling trigger, waiting to drop below lower
		ACQ_FALL_HIT,  // falling trigger, counting hits above upper
		ACQ_RISE_ARM,  // rising trigger, waiting to rise above upper
		ACQ_RISE_HIT,  // rising trigger, counting hits below lower
		ACQ_CAPTURE,   // post-trigger samples
		ACQ_HOLD       // event frozen until read out
	} acq_state_e;

	typedef enum logic [7:0] {
		TRIG_NONE = 8'd0,  // capture right away
		TRIG_FALL = 8'd1,
		TRIG_RISE = 8'd2
	} trig_type_e;

	// host settings seen by the trigger FSM, 61 bits
	typedef struct packed {
		sample_t     lower_thresh;
		sample_t     upper_thresh;
		logic [7:0]  tot_count;       // extra hits needed on the second condition
		logic [4:0]  downsample;      // write every 2^downsample cycles
		trig_type_e  trig_type;
		logic [15:0] length_to_take;  // writes after the trigger
	} acq_cfg_t;

	// event bookkeeping returned to the host side
	typedef struct packed {
		logic [15:0]           trigger_count;
		logic [15:0]           event_count;
		logic [BUF_AW_MAX-1:0] trig_addr;
	} acq_status_t;

endpackage

//--- common/scope_cmd_pkg.sv
//--------------------------------------------------------------------------
// scope command package
// host opcodes, the received 8-byte command word and host link constants
//--------------------------------------------------------------------------

package scope_cmd_pkg;

	// bytes per host command
	localparam int CMD_BYTES = 8;

	// READ_INFO sub-code that returns the firmware version
	localparam logic [7:0] INFO_VERSION = 8'd0;

	// first byte of every command
	typedef enum logic [7:0] {
		READOUT    = 8'd0,  // buffer readout from trigger address minus pre-offset
		ARM_STATUS = 8'd1,  // arm trigger, reply event and trigger counts
		READ_INFO  = 8'd2,  // version and other info
		TRIG_SET   = 8'd8,  // thresholds, pre-offset, time over threshold
		DS_SET     = 8'd9   // downsample exponent
	} cmd_op_e;

	// command as received, first byte on top
	typedef struct packed {
		logic [7:0] op;
		logic [7:0] byte1;
		logic [7:0] byte2;
		logic [7:0] byte3;
		logic [7:0] byte4;
		logic [7:0] byte5;
		logic [7:0] byte6;
		logic [7:0] byte7;
	} cmd_t;

endpackage
